// File: project.f
+incdir+verilog
verilog/axil_cdc_pkg.sv
verilog/axil_mem_if.sv
verilog/async_fifo.sv
verilog/axil_async_shim.sv
verilog/axil_sink_mem.sv
verilog/axil_cdc_top.sv
tests/tb_axil_cdc.sv

// File: Bender.yml
package:
  name: axil_cdc

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axil_cdc_pkg.sv
      - verilog/axil_mem_if.sv
      - verilog/async_fifo.sv
      - verilog/axil_async_shim.sv
      - verilog/axil_sink_mem.sv
      - verilog/axil_cdc_top.sv
      - target: test
        files:
          - tests/tb_axil_cdc.sv

// File: tests/tb_axil_cdc.sv
// testbench for the AXI-lite clock crossing subsystem
// LFSR stimulus, shadow-memory reference and in-order response compare
`include "axil_cdc_macros.svh"

module tb_axil_cdc
    import axil_cdc_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HANDSHAKE_LIMIT = 200;

    logic clk, sink_clk, reset;
    logic awvalid, awready, wvalid, wready, bready, bvalid;
    logic arvalid, arready, rready, rvalid;
    logic [`AXIL_ADDR_WIDTH-1:0] awaddr, araddr;
    logic [`AXIL_DATA_WIDTH-1:0] wdata, rdata;
    logic [`AXIL_STRB_WIDTH-1:0] wstrb;
    logic [1:0]                  bresp, rresp;

    logic [31:0]                 lfsr;
    logic [`AXIL_DATA_WIDTH-1:0] shadow [`AXIL_MEM_WORDS];
    logic [1:0]                  exp_b [$];
    logic [33:0]                 exp_r [$];
    logic [1:0]                  ready_mode = 2'd0;
    int                          error_count = 0;
    int                          check_count = 0;

    axil_cdc_top u_axil_cdc_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        sink_clk = 1'b0;
        forever #3.5 sink_clk = ~sink_clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // upper selects bytes 128..255 and oob moves the address past the memory
    function automatic logic [11:0] word_addr(input logic oob, input logic upper);
        logic [31:0] bits;
        bits = rand_bits(5);
        return {3'b000, oob, upper, bits[4:0], 2'b00};
    endfunction

    // expected {data, resp} for one request, writes also update the shadow copy
    function automatic logic [33:0] ref_response(input logic is_write, input logic [11:0] addr,
                                                 input logic [31:0] data, input logic [3:0] strb);
        if (addr >= 12'd256) begin
            return {32'h0, RESP_SLVERR};
        end
        if (is_write) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    shadow[addr[7:2]][8*i +: 8] = data[8*i +: 8];
                end
            end
            return {32'h0, RESP_OKAY};
        end
        return {shadow[addr[7:2]], RESP_OKAY};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
    endtask

    task automatic abort_run(input string reason);
        $display("%s at %0t", reason, $time);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, error_count - errors_before);
    endtask

    // aw and w are raised together and dropped as each one transfers
    task automatic send_write(input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic aw_done;
        logic w_done;
        int   cycles;
        logic [33:0] expected;
        expected = ref_response(1'b1, addr, data, strb);
        exp_b.push_back(expected[1:0]);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cycles  = 0;
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (awvalid && awready === 1'b1)
                aw_done = 1'b1;
            if (wvalid && wready === 1'b1)
                w_done = 1'b1;
            @(negedge clk);
            if (aw_done)
                awvalid = 1'b0;
            if (w_done)
                wvalid = 1'b0;
            cycles++;
            if (cycles > HANDSHAKE_LIMIT)
                abort_run("write request was never accepted");
        end
    endtask

    task automatic send_read(input logic [11:0] addr);
        int cycles;
        exp_r.push_back(ref_response(1'b0, addr, 32'h0, 4'h0));
        arvalid = 1'b1;
        araddr  = addr;
        cycles  = 0;
        @(posedge clk);
        while (arready !== 1'b1) begin
            cycles++;
            if (cycles > HANDSHAKE_LIMIT)
                abort_run("read request was never accepted");
            @(posedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic wait_idle(input int limit);
        int cycles;
        cycles = 0;
        while (exp_b.size() != 0 || exp_r.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit)
                abort_run("responses still outstanding after timeout");
        end
    endtask

    // bready and rready stay high, toggle at random or are held low
    initial begin
        logic [31:0] gap_lfsr;
        gap_lfsr = 32'h0c171193;
        bready = 1'b1;
        rready = 1'b1;
        forever begin
            @(negedge clk);
            if (ready_mode == 2'd1) begin
                gap_lfsr = lfsr_step(gap_lfsr);
                bready = gap_lfsr[0];
                gap_lfsr = lfsr_step(gap_lfsr);
                rready = gap_lfsr[0];
            end else begin
                bready = (ready_mode == 2'd0);
                rready = (ready_mode == 2'd0);
            end
        end
    end

    // one expected entry is popped per b or r transfer
    always @(posedge clk) begin
        logic [33:0] exp_rd;
        logic [1:0]  exp_wr;
        if (bvalid === 1'b1 && bready) begin
            check_count++;
            if (exp_b.size() == 0) begin
                error_count++;
                $display("write response at %0t with no write outstanding", $time);
            end else begin
                exp_wr = exp_b.pop_front();
                if (bresp !== exp_wr)
                    report_mismatch("bresp", bresp, exp_wr);
            end
        end
        if (rvalid === 1'b1 && rready) begin
            check_count++;
            if (exp_r.size() == 0) begin
                error_count++;
                $display("read response at %0t with no read outstanding", $time);
            end else begin
                exp_rd = exp_r.pop_front();
                if (rresp !== exp_rd[1:0])
                    report_mismatch("rresp", rresp, exp_rd[1:0]);
                if (rdata !== exp_rd[33:2])
                    report_mismatch("rdata", rdata, exp_rd[33:2]);
            end
        end
    end

    initial begin
        int          cycles;
        int          test_errors;
        int          issued;
        logic [11:0] addr;
        logic [31:0] bits;
        logic [31:0] strb_bits;
        lfsr    = 32'h0c171193;
        reset   = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        arvalid = 1'b0;
        araddr  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_errors = error_count;
        check_count += 2;
        if (bvalid !== 1'b0)
            report_mismatch("bvalid", bvalid, 32'h0);
        if (rvalid !== 1'b0)
            report_mismatch("rvalid", rvalid, 32'h0);
        cycles = 0;
        while ({awready, wready, arready} !== 3'b111) begin
            @(negedge clk);
            cycles++;
            if (cycles > HANDSHAKE_LIMIT)
                abort_run("request ready never rose after reset");
        end
        finish_test("reset", test_errors);

        test_errors = error_count;
        bits = rand_bits(32);
        addr = word_addr(1'b0, bits[0]);
        send_write(addr, bits, 4'hf);
        wait_idle(HANDSHAKE_LIMIT);
        send_read(addr);
        wait_idle(HANDSHAKE_LIMIT);
        finish_test("write then read", test_errors);

        // full word first, then a partial merge over it
        test_errors = error_count;
        for (int n = 0; n < 8; n++) begin
            bits = rand_bits(32);
            addr = word_addr(1'b0, bits[0]);
            send_write(addr, bits, 4'hf);
            strb_bits = rand_bits(4);
            send_write(addr, rand_bits(32), strb_bits[3:0]);
            wait_idle(HANDSHAKE_LIMIT);
            send_read(addr);
            wait_idle(HANDSHAKE_LIMIT);
        end
        finish_test("partial strobes", test_errors);

        // 0x104 aliases word 1 in the low address bits
        test_errors = error_count;
        bits = rand_bits(32);
        send_write(12'h004, bits, 4'hf);
        send_write(12'h104, ~bits, 4'hf);
        wait_idle(HANDSHAKE_LIMIT);
        send_read(12'h104);
        send_read(12'h004);
        send_read(12'hffc);
        wait_idle(HANDSHAKE_LIMIT);
        finish_test("out of range", test_errors);

        // preload the upper half, random writes then stay low and reads stay high
        test_errors = error_count;
        for (int n = 0; n < 32; n++) begin
            send_write({4'h0, 1'b1, n[4:0], 2'b00}, rand_bits(32), 4'hf);
        end
        wait_idle(HANDSHAKE_LIMIT * 4);
        ready_mode = 2'd1;
        for (int n = 0; n < 60; n++) begin
            bits = rand_bits(8);
            if (bits[0]) begin
                addr = word_addr(bits[1] & bits[2], 1'b0);
                send_write(addr, rand_bits(32), bits[7:4]);
            end else begin
                send_read(word_addr(bits[1] & bits[2], 1'b1));
            end
        end
        wait_idle(HANDSHAKE_LIMIT * 10);
        ready_mode = 2'd0;
        finish_test("random traffic", test_errors);

        test_errors = error_count;
        ready_mode = 2'd2;
        issued = 0;
        while (awready === 1'b1 && issued < 48) begin
            addr = word_addr(1'b0, 1'b0);
            send_write(addr, rand_bits(32), 4'hf);
            issued++;
            repeat (10) @(negedge clk);
        end
        if (awready !== 1'b0)
            report_mismatch("awready", awready, 32'h0);
        ready_mode = 2'd0;
        wait_idle(HANDSHAKE_LIMIT * 4);
        finish_test("back-pressure", test_errors);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/axil_cdc_top.sv
// top level with plain AXI-lite ports
// the clock crossing shim feeds the sink-domain register memory
`include "axil_cdc_macros.svh"

module axil_cdc_top
    import axil_cdc_pkg::*;
(
    input  logic                        clk,
    input  logic                        sink_clk,
    input  logic                        reset,

    input  logic                        awvalid,
    input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,
    output logic                        awready,

    input  logic                        wvalid,
    input  logic [`AXIL_DATA_WIDTH-1:0] wdata,
    input  logic [`AXIL_STRB_WIDTH-1:0] wstrb,
    output logic                        wready,

    input  logic                        bready,
    output logic                        bvalid,
    output logic [1:0]                  bresp,

    input  logic                        arvalid,
    input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
    output logic                        arready,

    input  logic                        rready,
    output logic                        rvalid,
    output logic [`AXIL_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                  rresp
);

    axil_mem_if src_if (.clk(clk), .reset(reset));
    axil_mem_if snk_if (.clk(sink_clk), .reset(reset));

    // pack the host ports into the source-side channels
    assign src_if.awvalid = awvalid;
    assign src_if.aw      = axil_aw_t'{addr: awaddr};
    assign awready        = src_if.awready;

    assign src_if.wvalid  = wvalid;
    assign src_if.w       = axil_w_t'{data: wdata, strb: wstrb};
    assign wready         = src_if.wready;

    assign src_if.bready  = bready;
    assign bvalid         = src_if.bvalid;
    assign bresp          = src_if.b.resp;

    assign src_if.arvalid = arvalid;
    assign src_if.ar      = axil_ar_t'{addr: araddr};
    assign arready        = src_if.arready;

    assign src_if.rready  = rready;
    assign rvalid         = src_if.rvalid;
    assign rdata          = src_if.r.data;
    assign rresp          = src_if.r.resp;

    axil_async_shim u_shim (
        .mem_sink   (snk_if),
        .mem_source (src_if)
    );

    axil_sink_mem u_mem (
        .mem (snk_if)
    );

endmodule

// File: verilog/axil_sink_mem.sv
// AXI-lite responder with a small word memory
// one outstanding write and one outstanding read response
`include "axil_cdc_macros.svh"

module axil_sink_mem
    import axil_cdc_pkg::*;
(
    axil_mem_if.to_source mem
);

    localparam int IDX_WIDTH  = $clog2(`AXIL_MEM_WORDS);
    localparam int BYTE_BITS  = $clog2(`AXIL_STRB_WIDTH);
    localparam int MEM_BYTES  = `AXIL_MEM_WORDS * `AXIL_STRB_WIDTH;

    logic [`AXIL_DATA_WIDTH-1:0] words [`AXIL_MEM_WORDS];

    logic                 wr_accept;
    logic                 rd_accept;
    logic                 wr_in_range;
    logic                 rd_in_range;
    logic [IDX_WIDTH-1:0] wr_idx;
    logic [IDX_WIDTH-1:0] rd_idx;

    logic    bvalid_q;
    logic    rvalid_q;
    axil_b_t b_q;
    axil_r_t r_q;

    // a write needs address and data together and no pending response
    assign wr_accept = mem.awvalid & mem.wvalid & ~bvalid_q;
    assign rd_accept = mem.arvalid & ~rvalid_q;

    assign mem.awready = mem.wvalid & ~bvalid_q;
    assign mem.wready  = mem.awvalid & ~bvalid_q;
    assign mem.arready = ~rvalid_q;

    assign wr_in_range = (mem.aw.addr < MEM_BYTES);
    assign rd_in_range = (mem.ar.addr < MEM_BYTES);
    assign wr_idx      = mem.aw.addr[BYTE_BITS +: IDX_WIDTH];
    assign rd_idx      = mem.ar.addr[BYTE_BITS +: IDX_WIDTH];

    // byte merge under the strobes, out-of-range writes are dropped
    always_ff @(posedge mem.clk) begin
        if (wr_accept && wr_in_range) begin
            for (int i = 0; i < `AXIL_STRB_WIDTH; i++) begin
                if (mem.w.strb[i]) begin
                    words[wr_idx][8*i +: 8] <= mem.w.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge mem.clk) begin
        if (wr_accept) begin
            b_q.resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_accept) begin
            r_q.data <= rd_in_range ? words[rd_idx] : '0;
            r_q.resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // responses are held until taken
    always_ff @(posedge mem.clk) begin
        if (mem.reset) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid_q <= 1'b1;
            end else if (mem.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_accept) begin
                rvalid_q <= 1'b1;
            end else if (mem.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    assign mem.bvalid = bvalid_q;
    assign mem.b      = b_q;
    assign mem.rvalid = rvalid_q;
    assign mem.r      = r_q;

endmodule

// File: verilog/axil_async_shim.sv
// AXI-lite clock crossing, one async FIFO per channel
// reset is resynchronized into each domain
module axil_async_shim
    import axil_cdc_pkg::*;
#(
    parameter int DEPTH_LOG2 = 4
) (
    axil_mem_if.to_sink   mem_sink,
    axil_mem_if.to_source mem_source
);

    logic src_reset_meta;
    logic src_reset;
    logic snk_reset_meta;
    logic snk_reset;

    // response payloads carry the resp enum, cast back from raw bits
    logic [$bits(axil_b_t)-1:0] b_data;
    logic [$bits(axil_r_t)-1:0] r_data;

    always_ff @(posedge mem_source.clk) begin
        src_reset_meta <= mem_source.reset;
        src_reset      <= src_reset_meta;
    end

    always_ff @(posedge mem_sink.clk) begin
        snk_reset_meta <= mem_sink.reset;
        snk_reset      <= snk_reset_meta;
    end

    // requests, source to sink
    async_fifo #(.DATA_WIDTH($bits(axil_aw_t)), .DEPTH_LOG2(DEPTH_LOG2)) u_aw_fifo (
        .clk_in    (mem_source.clk),
        .reset_in  (src_reset),
        .ready_in  (mem_source.awready),
        .valid_in  (mem_source.awvalid),
        .data_in   (mem_source.aw),
        .clk_out   (mem_sink.clk),
        .reset_out (snk_reset),
        .ready_out (mem_sink.awready),
        .valid_out (mem_sink.awvalid),
        .data_out  (mem_sink.aw)
    );

    async_fifo #(.DATA_WIDTH($bits(axil_w_t)), .DEPTH_LOG2(DEPTH_LOG2)) u_w_fifo (
        .clk_in    (mem_source.clk),
        .reset_in  (src_reset),
        .ready_in  (mem_source.wready),
        .valid_in  (mem_source.wvalid),
        .data_in   (mem_source.w),
        .clk_out   (mem_sink.clk),
        .reset_out (snk_reset),
        .ready_out (mem_sink.wready),
        .valid_out (mem_sink.wvalid),
        .data_out  (mem_sink.w)
    );

    async_fifo #(.DATA_WIDTH($bits(axil_ar_t)), .DEPTH_LOG2(DEPTH_LOG2)) u_ar_fifo (
        .clk_in    (mem_source.clk),
        .reset_in  (src_reset),
        .ready_in  (mem_source.arready),
        .valid_in  (mem_source.arvalid),
        .data_in   (mem_source.ar),
        .clk_out   (mem_sink.clk),
        .reset_out (snk_reset),
        .ready_out (mem_sink.arready),
        .valid_out (mem_sink.arvalid),
        .data_out  (mem_sink.ar)
    );

    // responses, sink back to source
    async_fifo #(.DATA_WIDTH($bits(axil_b_t)), .DEPTH_LOG2(DEPTH_LOG2)) u_b_fifo (
        .clk_in    (mem_sink.clk),
        .reset_in  (snk_reset),
        .ready_in  (mem_sink.bready),
        .valid_in  (mem_sink.bvalid),
        .data_in   (mem_sink.b),
        .clk_out   (mem_source.clk),
        .reset_out (src_reset),
        .ready_out (mem_source.bready),
        .valid_out (mem_source.bvalid),
        .data_out  (b_data)
    );

    async_fifo #(.DATA_WIDTH($bits(axil_r_t)), .DEPTH_LOG2(DEPTH_LOG2)) u_r_fifo (
        .clk_in    (mem_sink.clk),
        .reset_in  (snk_reset),
        .ready_in  (mem_sink.rready),
        .valid_in  (mem_sink.rvalid),
        .data_in   (mem_sink.r),
        .clk_out   (mem_source.clk),
        .reset_out (src_reset),
        .ready_out (mem_source.rready),
        .valid_out (mem_source.rvalid),
        .data_out  (r_data)
    );

    assign mem_source.b = axil_b_t'(b_data);
    assign mem_source.r = axil_r_t'(r_data);

endmodule

// File: verilog/async_fifo.sv
// valid/ready asynchronous FIFO
// gray-coded pointers cross each way through two flops
module async_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                  clk_in,
    input  logic                  reset_in,
    output logic                  ready_in,
    input  logic                  valid_in,
    input  logic [DATA_WIDTH-1:0] data_in,

    input  logic                  clk_out,
    input  logic                  reset_out,
    input  logic                  ready_out,
    output logic                  valid_out,
    output logic [DATA_WIDTH-1:0] data_out
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [DATA_WIDTH-1:0] fifo_mem [DEPTH];

    // write domain
    logic                push;
    logic [DEPTH_LOG2:0] wr_bin;
    logic [DEPTH_LOG2:0] wr_bin_next;
    logic [DEPTH_LOG2:0] wr_gray;
    logic [DEPTH_LOG2:0] wr_gray_next;
    logic [DEPTH_LOG2:0] rd_gray_s1;
    logic [DEPTH_LOG2:0] rd_gray_s2;
    logic [DEPTH_LOG2:0] full_gray;

    // read domain
    logic                pop;
    logic [DEPTH_LOG2:0] rd_bin;
    logic [DEPTH_LOG2:0] rd_bin_next;
    logic [DEPTH_LOG2:0] rd_gray;
    logic [DEPTH_LOG2:0] rd_gray_next;
    logic [DEPTH_LOG2:0] wr_gray_s1;
    logic [DEPTH_LOG2:0] wr_gray_s2;

    function automatic logic [DEPTH_LOG2:0] bin2gray(input logic [DEPTH_LOG2:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    assign push         = valid_in & ready_in;
    assign wr_bin_next  = wr_bin + {{DEPTH_LOG2{1'b0}}, push};
    assign wr_gray_next = bin2gray(wr_bin_next);

    // full once the write pointer is a whole lap ahead of the read pointer
    assign full_gray = {~rd_gray_s2[DEPTH_LOG2 -: 2], rd_gray_s2[DEPTH_LOG2-2:0]};

    always_ff @(posedge clk_in) begin
        if (reset_in) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            ready_in   <= 1'b0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_gray_next;
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            ready_in   <= (wr_gray_next != full_gray);
        end
    end

    always_ff @(posedge clk_in) begin
        if (push) begin
            fifo_mem[wr_bin[DEPTH_LOG2-1:0]] <= data_in;
        end
    end

    assign pop          = valid_out & ready_out;
    assign rd_bin_next  = rd_bin + {{DEPTH_LOG2{1'b0}}, pop};
    assign rd_gray_next = bin2gray(rd_bin_next);

    always_ff @(posedge clk_out) begin
        if (reset_out) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            valid_out  <= 1'b0;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_gray_next;
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            // empty when both pointers meet
            valid_out  <= (rd_gray_next != wr_gray_s2);
        end
    end

    // head entry stays put until the synchronized pointer moves past it
    assign data_out = fifo_mem[rd_bin[DEPTH_LOG2-1:0]];

endmodule

// File: verilog/axil_mem_if.sv
// five-channel AXI-lite interface with its clock and reset
interface axil_mem_if
    import axil_cdc_pkg::*;
(
    input logic clk,
    input logic reset
);

    logic     awvalid;
    logic     awready;
    axil_aw_t aw;

    logic     wvalid;
    logic     wready;
    axil_w_t  w;

    logic     bvalid;
    logic     bready;
    axil_b_t  b;

    logic     arvalid;
    logic     arready;
    axil_ar_t ar;

    logic     rvalid;
    logic     rready;
    axil_r_t  r;

    // request side, pushes aw/w/ar toward the responder
    modport to_sink (
        input  clk, reset,
        output awvalid, aw, wvalid, w, arvalid, ar, bready, rready,
        input  awready, wready, arready, bvalid, b, rvalid, r
    );

    // responder side
    modport to_source (
        input  clk, reset,
        input  awvalid, aw, wvalid, w, arvalid, ar, bready, rready,
        output awready, wready, arready, bvalid, b, rvalid, r
    );

endinterface

// File: verilog/axil_cdc_pkg.sv
// AXI-lite channel payload structs and the response enum
`include "axil_cdc_macros.svh"

package axil_cdc_pkg;

    // only the two responses this design returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // write address
    typedef struct packed {
        logic [`AXIL_ADDR_WIDTH-1:0] addr;
    } axil_aw_t;

    // write data with byte strobes
    typedef struct packed {
        logic [`AXIL_DATA_WIDTH-1:0] data;
        logic [`AXIL_STRB_WIDTH-1:0] strb;
    } axil_w_t;

    // write response
    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    // read address
    typedef struct packed {
        logic [`AXIL_ADDR_WIDTH-1:0] addr;
    } axil_ar_t;

    // read data and response
    typedef struct packed {
        logic [`AXIL_DATA_WIDTH-1:0] data;
        axil_resp_e                  resp;
    } axil_r_t;

endpackage

// File: verilog/axil_cdc_macros.svh
// AXI-lite widths and the sink memory size
// shared by the package and the modules that size their ports from them
`ifndef AXIL_CDC_MACROS_SVH
`define AXIL_CDC_MACROS_SVH

// byte address width on aw and ar
`define AXIL_ADDR_WIDTH 12

// data width on w and r
`define AXIL_DATA_WIDTH 32

// one strobe bit per data byte
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

// sink memory words, byte addresses 0 to 255
`define AXIL_MEM_WORDS 64

`endif
